//--- design/bcd_pkg.sv
package bcd_pkg;

    // Binary input side
    typedef logic [13:0] bin_value_t;  // Raw input, 14 bits cover 0 to 16383

    // Decimal side
    typedef logic [3:0] bcd_digit_t;  // One decimal digit, codes 10 to 15 unused

    localparam int BCD_DIGITS = 4;  // Digits per channel

    localparam bin_value_t MAX_DISPLAY_VALUE = bin_value_t'(9999);  // Saturation limit

    // One shift per input bit
    localparam int CONVERT_CYCLES = $bits(bin_value_t);

    // Edges from accepting a value to the commit edge
    localparam int CONVERT_LATENCY = CONVERT_CYCLES + 1;

    localparam int CREDITS_PER_CHANNEL = 1;  // Converter holds a single value

    // Converter FSM
    typedef enum logic [1:0] {
        IDLE,    // Waiting for a value
        SHIFT,   // Shift-and-add-3 steps
        COMMIT   // Hand digits to the scanner
    } conv_state_t;

endpackage

//--- design/display_pkg.sv
package display_pkg;

    import bcd_pkg::*;

    typedef logic [6:0] segment_t;  // Cathodes g..a, active low
    typedef logic [7:0] anode_t;    // Digit select, active low

    localparam int DISPLAY_DIGITS = 8;  // Four per channel

    localparam int DEFAULT_DWELL_CYCLES = 100000;  // About 1 ms per digit at 100 MHz

    localparam segment_t SEG_BLANK = 7'b111_1111;  // All cathodes off

    // Digit code to cathode pattern
    function automatic segment_t digit_to_segment(input bcd_digit_t digit);
        segment_t pattern;  // Pattern for this code
        case (digit)
            4'd0:    pattern = 7'b100_0000;
            4'd1:    pattern = 7'b111_1001;
            4'd2:    pattern = 7'b010_0100;
            4'd3:    pattern = 7'b011_0000;
            4'd4:    pattern = 7'b001_1001;
            4'd5:    pattern = 7'b001_0010;
            4'd6:    pattern = 7'b000_0010;
            4'd7:    pattern = 7'b111_1000;
            4'd8:    pattern = 7'b000_0000;
            4'd9:    pattern = 7'b001_0000;
            default: pattern = SEG_BLANK;  // Non-decimal codes stay dark
        endcase
        return pattern;
    endfunction

endpackage

//--- design/bcd_converter.sv
`timescale 1ns/10ps
module bcd_converter import bcd_pkg::*; (
    input  logic       CLK100MHz,  // System clock
    input  logic       reset,      // Async reset, active high
    input  logic       valid,      // One-cycle strobe, spends the credit
    input  bin_value_t value,      // Binary value, stable while valid
    output bcd_digit_t ones,       // Result digits
    output bcd_digit_t tens,
    output bcd_digit_t hundreds,
    output bcd_digit_t thousands,
    output logic       load,       // Scanner captures digits on this
    output logic       credit      // Credit back to the producer
);

    localparam int STEP_W = $clog2(CONVERT_CYCLES);   // Shift step counter width
    localparam int MSB    = $bits(bin_value_t) - 1;   // Input bit shifted in next
    localparam int FLIGHT_W = $clog2(CREDITS_PER_CHANNEL + 1);

    conv_state_t                 state;      // Converter FSM
    logic        [STEP_W-1:0]    step;       // Shifts done so far
    bin_value_t                  clamped;    // Input after saturation
    bin_value_t                  shift_reg;  // Remaining input bits, MSB first
    bcd_digit_t  [BCD_DIGITS-1:0] work;      // Working BCD, [0] is ones
    bcd_digit_t  [BCD_DIGITS-1:0] adj;       // Work after add-3 correction
    logic        [4*BCD_DIGITS:0] shifted;   // Corrected digits plus next bit
    logic        [FLIGHT_W-1:0]  in_flight;  // Credits spent, not yet returned

    // Above 9999 shows as 9999
    assign clamped = (value > MAX_DISPLAY_VALUE) ? MAX_DISPLAY_VALUE : value;

    // Add 3 to every digit of 5 or more before the shift
    always_comb begin
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (work[i] >= bcd_digit_t'(5)) begin
                adj[i] = work[i] + bcd_digit_t'(3);
            end else begin
                adj[i] = work[i];
            end
        end
    end

    assign shifted = {adj, shift_reg[MSB]};  // Top bit stays zero for values up to 9999

    // Control FSM
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            step   <= '0;
            load   <= 1'b0;
            credit <= 1'b0;
        end else begin
            load   <= 1'b0;  // Strobes last one cycle
            credit <= 1'b0;
            case (state)
                IDLE: begin
                    if (valid) begin
                        state <= SHIFT;  // Accepting edge
                        step  <= '0;
                    end
                end
                SHIFT: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(CONVERT_CYCLES - 1)) begin
                        state <= COMMIT;  // Last shift on this edge
                    end
                end
                COMMIT: begin
                    state  <= IDLE;
                    load   <= 1'b1;  // Digits land in the scanner next edge
                    credit <= 1'b1;  // Same cycle as load
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
            work      <= '0;
            ones      <= '0;  // Result reads 0000
            tens      <= '0;
            hundreds  <= '0;
            thousands <= '0;
        end else if (state == IDLE && valid) begin
            shift_reg <= clamped;
            work      <= '0;
        end else if (state == SHIFT) begin
            shift_reg <= shift_reg << 1;
            work      <= shifted[4*BCD_DIGITS-1:0];
        end else if (state == COMMIT) begin
            ones      <= work[0];
            tens      <= work[1];
            hundreds  <= work[2];
            thousands <= work[3];
        end
    end

    // Producer-side credit tracking for the protocol check
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            in_flight <= '0;
        end else if (valid && !credit) begin
            in_flight <= in_flight + 1'b1;
        end else if (credit && !valid) begin
            in_flight <= in_flight - 1'b1;
        end
    end

    // A valid only arrives with a credit in hand, which keeps it in IDLE
    a_valid_with_credit: assert property (@(posedge CLK100MHz) disable iff (reset)
        valid |-> (state == IDLE) && (in_flight < CREDITS_PER_CHANNEL || credit))
        else $error("valid seen without a credit or outside IDLE");

    // Result and credit together, a fixed distance after the accepting edge
    a_commit_latency: assert property (@(posedge CLK100MHz) disable iff (reset)
        (valid && state == IDLE) |=> ##CONVERT_LATENCY (credit && load))
        else $error("credit and load not on schedule");

endmodule

//--- design/segment_scanner.sv
`timescale 1ns/10ps
module segment_scanner import bcd_pkg::*, display_pkg::*; #(
    parameter int dwell_cycles = DEFAULT_DWELL_CYCLES  // Clocks per digit, any positive value
) (
    input  logic       CLK100MHz,    // System clock
    input  logic       reset,        // Async reset, active high
    input  logic       a_load,       // Channel A digits valid
    input  bcd_digit_t a_ones,
    input  bcd_digit_t a_tens,
    input  bcd_digit_t a_hundreds,
    input  bcd_digit_t a_thousands,
    input  logic       b_load,       // Channel B digits valid
    input  bcd_digit_t b_ones,
    input  bcd_digit_t b_tens,
    input  bcd_digit_t b_hundreds,
    input  bcd_digit_t b_thousands,
    output segment_t   seg,          // Cathodes, active low
    output anode_t     an            // One low bit selects the lit digit
);

    localparam int DWELL_W = $clog2(dwell_cycles + 1);   // Holds 0 to dwell_cycles-1
    localparam int INDEX_W = $clog2(DISPLAY_DIGITS);

    bcd_digit_t [DISPLAY_DIGITS-1:0] digit_reg;   // [7:4] channel A, [3:0] channel B
    logic       [DWELL_W-1:0]        dwell_cnt;   // Clocks spent on current digit
    logic       [INDEX_W-1:0]        digit_idx;   // Lit digit, 7 is leftmost
    logic                            dwell_done;  // Last clock of this digit

    assign dwell_done = (dwell_cnt == DWELL_W'(dwell_cycles - 1));

    // Digit store, each half on its own strobe
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            digit_reg <= '0;  // Display reads 00000000
        end else begin
            if (a_load) begin
                digit_reg[7] <= a_thousands;  // Left half
                digit_reg[6] <= a_hundreds;
                digit_reg[5] <= a_tens;
                digit_reg[4] <= a_ones;
            end
            if (b_load) begin
                digit_reg[3] <= b_thousands;  // Right half
                digit_reg[2] <= b_hundreds;
                digit_reg[1] <= b_tens;
                digit_reg[0] <= b_ones;
            end
        end
    end

    // Dwell counter and digit index
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            dwell_cnt <= '0;
            digit_idx <= INDEX_W'(DISPLAY_DIGITS - 1);  // Start on digit 7
        end else if (dwell_done) begin
            dwell_cnt <= '0;
            digit_idx <= digit_idx - 1'b1;  // 0 wraps back to 7
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign seg = digit_to_segment(digit_reg[digit_idx]);
    assign an  = ~(anode_t'(1) << digit_idx);

    // Exactly one digit lit
    a_one_anode: assert property (@(posedge CLK100MHz) disable iff (reset)
        $onehot(~an))
        else $error("anode select not one-hot-low");

endmodule

//--- design/dual_decimal_display.sv
`timescale 1ns/10ps
module dual_decimal_display import bcd_pkg::*, display_pkg::*; #(
    parameter int dwell_cycles = DEFAULT_DWELL_CYCLES  // Scanner dwell in clocks
) (
    input  logic       CLK100MHz,  // Board clock
    input  logic       reset,      // Async reset, active high
    input  logic       a_valid,    // Channel A, left four digits
    input  bin_value_t a_value,
    output logic       a_credit,
    input  logic       b_valid,    // Channel B, right four digits
    input  bin_value_t b_value,
    output logic       b_credit,
    output segment_t   seg,        // Shared cathodes
    output anode_t     an          // Shared anodes
);

    bcd_digit_t a_ones;  // Channel A result
    bcd_digit_t a_tens;
    bcd_digit_t a_hundreds;
    bcd_digit_t a_thousands;
    logic       a_load;
    bcd_digit_t b_ones;  // Channel B result
    bcd_digit_t b_tens;
    bcd_digit_t b_hundreds;
    bcd_digit_t b_thousands;
    logic       b_load;

    bcd_converter u_conv_a (
        .CLK100MHz (CLK100MHz),
        .reset     (reset),
        .valid     (a_valid),
        .value     (a_value),
        .ones      (a_ones),
        .tens      (a_tens),
        .hundreds  (a_hundreds),
        .thousands (a_thousands),
        .load      (a_load),
        .credit    (a_credit)
    );

    bcd_converter u_conv_b (
        .CLK100MHz (CLK100MHz),
        .reset     (reset),
        .valid     (b_valid),
        .value     (b_value),
        .ones      (b_ones),
        .tens      (b_tens),
        .hundreds  (b_hundreds),
        .thousands (b_thousands),
        .load      (b_load),
        .credit    (b_credit)
    );

    segment_scanner #(
        .dwell_cycles (dwell_cycles)
    ) u_scan (
        .CLK100MHz   (CLK100MHz),
        .reset       (reset),
        .a_load      (a_load),
        .a_ones      (a_ones),
        .a_tens      (a_tens),
        .a_hundreds  (a_hundreds),
        .a_thousands (a_thousands),
        .b_load      (b_load),
        .b_ones      (b_ones),
        .b_tens      (b_tens),
        .b_hundreds  (b_hundreds),
        .b_thousands (b_thousands),
        .seg         (seg),
        .an          (an)
    );

endmodule

//--- sim/tb_dual_decimal_display.sv
`timescale 1ns/10ps
module tb_dual_decimal_display
    import bcd_pkg::*, display_pkg::*;
();

    localparam int DWELL          = 4;           // Short dwell, full scan in 32 clocks
    localparam int SCAN_CYCLES    = DWELL * 8;
    localparam int CREDIT_LATENCY = 15;          // Accepting edge to credit cycle
    localparam int SATURATE_AT    = 9999;        // Largest value the display can show
    localparam int CREDIT_TIMEOUT = 100;         // Clocks allowed for a credit
    localparam int RANDOM_PER_CH  = 100;         // 200 random values over both channels

    logic       CLK100MHz;
    logic       reset;
    logic       a_valid;
    bin_value_t a_value;
    logic       a_credit;
    logic       b_valid;
    bin_value_t b_value;
    logic       b_credit;
    segment_t   seg;
    anode_t     an;

    int         errors;            // Failed checks
    int         timeouts;          // Waits that ran out
    int         credits [2];       // Producer credit counters, [0] is A
    logic       stable [2];        // Half is checked only between conversions
    int         exp_digit [8];     // Expected digit per display position
    int         scan_cnt;          // Clocks since reset release
    int         lit_idx;           // Position whose anode is low
    int         lit_digit;         // Digit decoded from the cathodes
    int         lit_expected;
    anode_t     an_expected;       // Scan model output
    int         unused_seed;
    bin_value_t directed [9] = '{0, 9, 10, 99, 1000, 9999, 10000, 12345, 16383};

    dual_decimal_display #(
        .dwell_cycles (DWELL)
    ) u_dut (
        .CLK100MHz (CLK100MHz),
        .reset     (reset),
        .a_valid   (a_valid),
        .a_value   (a_value),
        .a_credit  (a_credit),
        .b_valid   (b_valid),
        .b_value   (b_value),
        .b_credit  (b_credit),
        .seg       (seg),
        .an        (an)
    );

    always #5 CLK100MHz = ~CLK100MHz;  // 100 MHz

    // Cathodes g..a active low back to a digit, 15 when not a decimal pattern
    function automatic int segment_to_digit(input segment_t s);
        case (s)
            7'b100_0000: return 0;
            7'b111_1001: return 1;
            7'b010_0100: return 2;
            7'b011_0000: return 3;
            7'b001_1001: return 4;
            7'b001_0010: return 5;
            7'b000_0010: return 6;
            7'b111_1000: return 7;
            7'b000_0000: return 8;
            7'b001_0000: return 9;
            default:     return 15;
        endcase
    endfunction

    function automatic int lit_position(input anode_t a);
        int pos;
        pos = -1;  // None or several low
        for (int i = 0; i < 8; i++) begin
            if (a == ~(anode_t'(1) << i)) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // Saturated value split into four decimal digits from position base up
    task automatic store_expected(input int base, input int value);
        int shown;
        shown = (value > SATURATE_AT) ? SATURATE_AT : value;
        for (int i = 0; i < 4; i++) begin
            exp_digit[base + i] = shown % 10;
            shown = shown / 10;
        end
    endtask

    // One value through one channel, ch 0 is A
    task automatic send_value(input int ch, input bin_value_t value);
        int waited;
        waited = 0;
        @(negedge CLK100MHz);
        while (credits[ch] == 0 && waited < CREDIT_TIMEOUT) begin  // No credit, no valid
            @(negedge CLK100MHz);
            waited++;
        end
        if (credits[ch] == 0) begin
            timeouts++;
            $display("Timeout: channel %0d never got a credit to send %0d", ch, value);
        end else begin
            stable[ch] = 1'b0;
            credits[ch]--;  // Pulse spends the credit
            if (ch == 0) begin
                a_valid = 1'b1;
                a_value = value;
            end else begin
                b_valid = 1'b1;
                b_value = value;
            end
            @(negedge CLK100MHz);
            a_valid = (ch == 0) ? 1'b0 : a_valid;
            b_valid = (ch == 1) ? 1'b0 : b_valid;
            waited  = 0;
            while (credits[ch] < CREDITS_PER_CHANNEL && waited < CREDIT_TIMEOUT) begin
                @(negedge CLK100MHz);
                waited++;
                if ((ch == 0) ? a_credit : b_credit) begin
                    credits[ch]++;
                end
            end
            if (credits[ch] < CREDITS_PER_CHANNEL) begin
                timeouts++;
                $display("Timeout: channel %0d credit not returned for %0d", ch, value);
            end else begin
                @(negedge CLK100MHz);  // Scanner has captured the digits
                store_expected((ch == 0) ? 4 : 0, int'(value));
                stable[ch] = 1'b1;
                repeat (SCAN_CYCLES) @(negedge CLK100MHz);  // Every digit shown once
            end
        end
    endtask

    task automatic produce_a(input int count);
        repeat (count) begin
            repeat ($urandom % 24) @(negedge CLK100MHz);  // Random phase
            send_value(0, bin_value_t'($urandom % 16384));
        end
    endtask

    task automatic produce_b(input int count);
        repeat (count) begin
            repeat ($urandom % 24) @(negedge CLK100MHz);
            send_value(1, bin_value_t'($urandom % 16384));
        end
    endtask

    // Independent scan model
    always @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            scan_cnt <= 0;
        end else begin
            scan_cnt <= scan_cnt + 1;
        end
    end

    always_comb begin
        lit_idx      = lit_position(an);
        lit_digit    = segment_to_digit(seg);
        lit_expected = (lit_idx >= 0) ? exp_digit[lit_idx] : -1;
        an_expected  = ~(anode_t'(1) << (7 - (scan_cnt / DWELL) % 8));  // 7 down to 0
    end

    credit_a_timing: assert property (@(posedge CLK100MHz) disable iff (reset)
        a_valid |=> (!a_credit) [*CREDIT_LATENCY] ##1 a_credit ##1 !a_credit)
        else begin
            errors++;
            $display("CHECK FAILED credit_a_timing expected 1-cycle pulse at +15 actual %0b",
                     $sampled(a_credit));
        end
    credit_b_timing: assert property (@(posedge CLK100MHz) disable iff (reset)
        b_valid |=> (!b_credit) [*CREDIT_LATENCY] ##1 b_credit ##1 !b_credit)
        else begin
            errors++;
            $display("CHECK FAILED credit_b_timing expected 1-cycle pulse at +15 actual %0b",
                     $sampled(b_credit));
        end
    credit_a_source: assert property (@(posedge CLK100MHz) disable iff (reset)
        a_credit |-> $past(a_valid, CREDIT_LATENCY + 1))
        else begin
            errors++;
            $display("CHECK FAILED credit_a_source expected 0 actual 1");
        end
    credit_b_source: assert property (@(posedge CLK100MHz) disable iff (reset)
        b_credit |-> $past(b_valid, CREDIT_LATENCY + 1))
        else begin
            errors++;
            $display("CHECK FAILED credit_b_source expected 0 actual 1");
        end
    left_digits: assert property (@(posedge CLK100MHz) disable iff (reset)
        (stable[0] && lit_idx >= 4) |-> (lit_digit == lit_expected))
        else begin
            errors++;
            $display("CHECK FAILED left_digits digit %0d expected %0d actual %0d",
                     $sampled(lit_idx), $sampled(lit_expected), $sampled(lit_digit));
        end
    right_digits: assert property (@(posedge CLK100MHz) disable iff (reset)
        (stable[1] && lit_idx >= 0 && lit_idx < 4) |-> (lit_digit == lit_expected))
        else begin
            errors++;
            $display("CHECK FAILED right_digits digit %0d expected %0d actual %0d",
                     $sampled(lit_idx), $sampled(lit_expected), $sampled(lit_digit));
        end
    anode_schedule: assert property (@(posedge CLK100MHz) disable iff (reset)
        an == an_expected)  // One low bit, right place, right time
        else begin
            errors++;
            $display("CHECK FAILED anode_schedule expected %b actual %b",
                     $sampled(an_expected), $sampled(an));
        end

    initial begin
        CLK100MHz   = 1'b0;
        reset       = 1'b1;
        a_valid     = 1'b0;
        a_value     = '0;
        b_valid     = 1'b0;
        b_value     = '0;
        errors      = 0;
        timeouts    = 0;
        credits[0]  = CREDITS_PER_CHANNEL;  // Producer starts with its credit
        credits[1]  = CREDITS_PER_CHANNEL;
        stable[0]   = 1'b1;
        stable[1]   = 1'b1;
        for (int i = 0; i < 8; i++) begin
            exp_digit[i] = 0;  // Reset display reads 00000000
        end
        unused_seed = $urandom(68661);
        repeat (10) @(negedge CLK100MHz);
        reset = 1'b0;
        repeat (SCAN_CYCLES) @(negedge CLK100MHz);  // Zeros after reset
        for (int i = 0; i < 9; i++) begin
            fork
                send_value(0, directed[i]);
                send_value(1, directed[8 - i]);  // Opposite order on B
            join
        end
        fork
            produce_a(RANDOM_PER_CH);  // Channels at independent moments
            produce_b(RANDOM_PER_CH);
        join
        repeat (SCAN_CYCLES) @(negedge CLK100MHz);
        $display("Check failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/bcd_pkg.sv
design/display_pkg.sv
design/bcd_converter.sv
design/segment_scanner.sv
design/dual_decimal_display.sv
sim/tb_dual_decimal_display.sv
